// File: tb/packet_queue_testdata.txt
// Hex word per command: op, queue, value. Op 1 enqueues value bytes,
// op 2 dequeues expecting value as empty flag, op 3 checks the word count
100d
1106
1008
1214
3006
3205
2000
2301
2100
1324
2200
2201
121d
1128
310a
2300
2000
1034
3300
2200
2100
1330
2000
2300
3000
2101
120b
3203

// File: all.f
+incdir+common
common/queue_pkg.sv
queue_memory/queue_memory.sv
queue_memory/page_free_list.sv
verilog/queue_pointer_table.sv
verilog/queue_occupancy_counter.sv
verilog/dequeue_fsm.sv
verilog/packet_queue_top.sv
tb/packet_queue_tb.sv

// File: Bender.yml
package:
  name: packet_queue

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/queue_pkg.sv
      - queue_memory/queue_memory.sv
      - queue_memory/page_free_list.sv
      - verilog/queue_pointer_table.sv
      - verilog/queue_occupancy_counter.sv
      - verilog/dequeue_fsm.sv
      - verilog/packet_queue_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/packet_queue_tb.sv

// File: tb/packet_queue_tb.sv
////////////////////
// Testbench for the packet queue top level: command file, LFSR data,
// per-queue reference model, stall checks and a watchdog
////////////////////
`timescale 1ns/1ps
`include "queue_consts.svh"

module packet_queue_tb;
    import queue_pkg::*;

    localparam int CLK_HALF   = 10;
    localparam int MAX_CMDS   = 64;
    localparam int BYTE_SLOTS = 256;
    localparam int PKT_SLOTS  = 32;

    logic                             packet_in;
    logic                             arst_n;
    packet_word_t                     in_word;
    logic                             in_valid;
    logic                             in_ready;
    logic                             deq_req;
    logic [`QUEUE_NUM_QUEUES_LOG-1:0] deq_queue;
    logic                             deq_ack;
    logic                             deq_empty;
    out_word_t                        out_word;
    logic                             out_valid;
    logic                             out_ready;
    queue_occupancy_t                 occupancy;

    logic [15:0] commands [MAX_CMDS];
    int          num_cmds;
    logic [31:0] lfsr_state;

    // Reference model, byte ring and packet length ring per queue
    logic [7:0] ref_bytes   [`QUEUE_NUM_QUEUES][BYTE_SLOTS];
    int         byte_head   [`QUEUE_NUM_QUEUES];
    int         byte_tail   [`QUEUE_NUM_QUEUES];
    int         pkt_len     [`QUEUE_NUM_QUEUES][PKT_SLOTS];
    int         pkt_head    [`QUEUE_NUM_QUEUES];
    int         pkt_tail    [`QUEUE_NUM_QUEUES];
    int         model_words [`QUEUE_NUM_QUEUES];

    packet_queue_top dut0 (
        .packet_in (packet_in),
        .arst_n    (arst_n),
        .in_word   (in_word),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .deq_req   (deq_req),
        .deq_queue (deq_queue),
        .deq_ack   (deq_ack),
        .deq_empty (deq_empty),
        .out_word  (out_word),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .occupancy (occupancy)
    );

    initial begin
        packet_in = 1'b0;
        forever #CLK_HALF packet_in = ~packet_in;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            fail_run($sformatf("FAIL %0t ns: %s, got %0h, expected %0h",
                               $time, what, actual, expected));
        end
    endtask

    // Galois form, polynomial x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'hd000_0001;
        end
        return state >> 1;
    endfunction

    task automatic random_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic logic [`QUEUE_DATA_BYTES*8-1:0] byte_mask(
        input logic [`QUEUE_DATA_BYTES-1:0] keep
    );
        logic [`QUEUE_DATA_BYTES*8-1:0] mask;
        for (int j = 0; j < `QUEUE_DATA_BYTES; j++) begin
            mask[8*j +: 8] = {8{keep[j]}};
        end
        return mask;
    endfunction

    // Word idx of the oldest packet in the model of queue q
    function automatic out_word_t expected_word(input int q, input int len, input int idx);
        out_word_t w;
        int        pos;
        w = '0;
        for (int j = 0; j < `QUEUE_DATA_BYTES; j++) begin
            pos = idx * `QUEUE_DATA_BYTES + j;
            if (pos < len) begin
                w.data[8*j +: 8] = ref_bytes[q][(byte_head[q] + pos) % BYTE_SLOTS];
                w.keep[j]        = 1'b1;
            end
        end
        w.last  = (idx == (len + `QUEUE_DATA_BYTES - 1) / `QUEUE_DATA_BYTES - 1);
        w.queue = q[`QUEUE_NUM_QUEUES_LOG-1:0];
        return w;
    endfunction

    task automatic enqueue_packet(input int q, input int len);
        packet_word_t w;
        logic [31:0]  bits;
        int           nwords;
        int           pos;
        nwords = (len + `QUEUE_DATA_BYTES - 1) / `QUEUE_DATA_BYTES;
        for (int i = 0; i < nwords; i++) begin
            w = '0;
            for (int j = 0; j < `QUEUE_DATA_BYTES; j++) begin
                pos = i * `QUEUE_DATA_BYTES + j;
                if (pos < len) begin
                    random_bits(8, bits);
                    w.data[8*j +: 8] = bits[7:0];
                    w.keep[j]        = 1'b1;
                    ref_bytes[q][(byte_tail[q] + pos) % BYTE_SLOTS] = bits[7:0];
                end
            end
            w.last   = (i == nwords - 1);
            w.queue  = q[`QUEUE_NUM_QUEUES_LOG-1:0];
            in_word  = w;
            in_valid = 1'b1;
            #1;
            while (!in_ready) begin
                @(posedge packet_in);
                #3;
            end
            @(posedge packet_in);
            #2;
        end
        in_valid = 1'b0;
        byte_tail[q] += len;
        pkt_len[q][pkt_tail[q] % PKT_SLOTS] = len;
        pkt_tail[q]++;
        model_words[q] += nwords;
    endtask

    task automatic dequeue_packet(input int q, input logic expect_empty);
        out_word_t   exp_w;
        out_word_t   got;
        out_word_t   held;
        logic [31:0] bits;
        logic        stalled;
        int          len;
        int          nwords;
        int          rx;
        stalled = 1'b0;
        held    = '0;
        len     = 0;
        nwords  = 0;
        rx      = 0;
        if (!expect_empty) begin
            check_value(64'(pkt_tail[q] != pkt_head[q]), 64'(1), "model holds a packet");
            len    = pkt_len[q][pkt_head[q] % PKT_SLOTS];
            nwords = (len + `QUEUE_DATA_BYTES - 1) / `QUEUE_DATA_BYTES;
        end
        deq_queue = q[`QUEUE_NUM_QUEUES_LOG-1:0];
        deq_req   = 1'b1;
        @(posedge packet_in);
        #2;
        while (!deq_ack) begin
            if (stalled) begin
                check_value(64'(out_valid), 64'(1), "out_valid during stall");
                check_value(64'(out_word), 64'(held), "out_word during stall");
            end
            // Ready low about one cycle in four
            random_bits(2, bits);
            out_ready = |bits[1:0];
            stalled   = out_valid && !out_ready;
            held      = out_word;
            if (out_valid && out_ready) begin
                check_value(64'(rx < nwords), 64'(1), "word count within packet");
                exp_w    = expected_word(q, len, rx);
                got      = out_word;
                got.data = got.data & byte_mask(exp_w.keep);
                check_value(64'(got), 64'(exp_w), $sformatf("queue %0d word %0d", q, rx));
                rx++;
            end
            @(posedge packet_in);
            #2;
        end
        check_value(64'(deq_empty), 64'(expect_empty), "deq_empty");
        check_value(64'(rx), 64'(nwords), "words in packet");
        deq_req   = 1'b0;
        out_ready = 1'b0;
        while (deq_ack) begin
            @(posedge packet_in);
            #2;
        end
        if (!expect_empty) begin
            byte_head[q] += len;
            pkt_head[q]++;
            model_words[q] -= nwords;
        end
    endtask

    task automatic check_occupancy(input int q, input int expected);
        check_value(64'(occupancy[q]), 64'(expected), $sformatf("occupancy of queue %0d", q));
        check_value(64'(occupancy[q]), 64'(model_words[q]), "occupancy against model");
    endtask

    ////////////////////
    // Watchdog
    initial begin
        wait (num_cmds > 0);
        repeat (num_cmds * 200) @(posedge packet_in);
        fail_run("ERROR: watchdog expired before the command list finished");
    end

    ////////////////////
    // Command sequence
    initial begin
        int count;
        int op;
        int q;
        int value;
        arst_n     = 1'b0;
        in_word    = '0;
        in_valid   = 1'b0;
        deq_req    = 1'b0;
        deq_queue  = '0;
        out_ready  = 1'b0;
        lfsr_state = 32'hb23467ca;
        num_cmds   = 0;
        for (int i = 0; i < `QUEUE_NUM_QUEUES; i++) begin
            byte_head[i]   = 0;
            byte_tail[i]   = 0;
            pkt_head[i]    = 0;
            pkt_tail[i]    = 0;
            model_words[i] = 0;
        end
        for (int i = 0; i < MAX_CMDS; i++) begin
            commands[i] = '0;
        end
        $readmemh("tb/packet_queue_testdata.txt", commands);
        count = 0;
        while (count < MAX_CMDS && commands[count][15:12] != 4'h0) begin
            count++;
        end
        if (count == 0) begin
            fail_run("ERROR: no commands found in the data file");
        end
        num_cmds = count;
        repeat (4) @(posedge packet_in);
        #2;
        arst_n = 1'b1;
        @(posedge packet_in);
        #2;
        for (int i = 0; i < num_cmds; i++) begin
            op    = commands[i][15:12];
            q     = commands[i][11:8];
            value = commands[i][7:0];
            case (op)
                1: enqueue_packet(q, value);
                2: dequeue_packet(q, value[0]);
                3: check_occupancy(q, value);
                default: fail_run($sformatf("ERROR: unknown command %h at entry %0d",
                                            commands[i], i));
            endcase
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// File: verilog/packet_queue_top.sv
////////////////////
// Paged packet queue buffer top level
////////////////////
`timescale 1ns/1ps
`include "queue_consts.svh"

module packet_queue_top (
    input  logic                             packet_in,
    input  logic                             arst_n,
    input  queue_pkg::packet_word_t          in_word,
    input  logic                             in_valid,
    output logic                             in_ready,
    input  logic                             deq_req,
    input  logic [`QUEUE_NUM_QUEUES_LOG-1:0] deq_queue,
    output logic                             deq_ack,
    output logic                             deq_empty,
    output queue_pkg::out_word_t             out_word,
    output logic                             out_valid,
    input  logic                             out_ready,
    output queue_pkg::queue_occupancy_t      occupancy
);
    import queue_pkg::*;

    logic                             alloc_take;
    logic                             alloc_avail;
    logic [`QUEUE_NUM_PAGES_LOG-1:0]  alloc_page;
    logic                             free_valid;
    logic [`QUEUE_NUM_PAGES_LOG-1:0]  free_page;
    logic                             wr_en;
    mem_addr_t                        wr_addr;
    packet_word_t                     wr_word;
    mem_addr_t                        rd_addr;
    out_word_t                        rd_word;
    logic [`QUEUE_NUM_QUEUES-1:0]     queue_empty;
    logic [`QUEUE_NUM_QUEUES_LOG-1:0] rd_queue;
    logic                             rd_advance;

    queue_memory u_memory (
        .packet_in (packet_in),
        .arst_n    (arst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_word   (wr_word),
        .rd_addr   (rd_addr),
        .rd_word   (rd_word)
    );

    page_free_list u_free_list (
        .packet_in   (packet_in),
        .arst_n      (arst_n),
        .alloc_take  (alloc_take),
        .free_valid  (free_valid),
        .free_page   (free_page),
        .alloc_page  (alloc_page),
        .alloc_avail (alloc_avail)
    );

    queue_pointer_table u_pointer_table (
        .packet_in   (packet_in),
        .arst_n      (arst_n),
        .in_word     (in_word),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .queue_empty (queue_empty),
        .alloc_page  (alloc_page),
        .alloc_avail (alloc_avail),
        .alloc_take  (alloc_take),
        .free_valid  (free_valid),
        .free_page   (free_page),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_word     (wr_word),
        .rd_queue    (rd_queue),
        .rd_advance  (rd_advance),
        .rd_addr     (rd_addr)
    );

    queue_occupancy_counter u_occupancy (
        .packet_in   (packet_in),
        .arst_n      (arst_n),
        .wr_en       (wr_en),
        .wr_queue    (wr_word.queue),
        .rd_advance  (rd_advance),
        .rd_queue    (rd_queue),
        .occupancy   (occupancy),
        .queue_empty (queue_empty)
    );

    dequeue_fsm u_dequeue (
        .packet_in   (packet_in),
        .arst_n      (arst_n),
        .deq_req     (deq_req),
        .deq_queue   (deq_queue),
        .deq_ack     (deq_ack),
        .deq_empty   (deq_empty),
        .queue_empty (queue_empty),
        .rd_queue    (rd_queue),
        .rd_advance  (rd_advance),
        .rd_word     (rd_word),
        .out_word    (out_word),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

// File: verilog/dequeue_fsm.sv
////////////////////
// Scheduler handshake and word-by-word read of one packet
////////////////////
`timescale 1ns/1ps
`include "queue_consts.svh"

module dequeue_fsm (
    input  logic                             packet_in,
    input  logic                             arst_n,
    input  logic                             deq_req,
    input  logic [`QUEUE_NUM_QUEUES_LOG-1:0] deq_queue,
    output logic                             deq_ack,
    output logic                             deq_empty,
    input  logic [`QUEUE_NUM_QUEUES-1:0]     queue_empty,
    output logic [`QUEUE_NUM_QUEUES_LOG-1:0] rd_queue,
    output logic                             rd_advance,
    input  queue_pkg::out_word_t             rd_word,
    output queue_pkg::out_word_t             out_word,
    output logic                             out_valid,
    input  logic                             out_ready
);
    import queue_pkg::*;

    deq_state_t state;

    assign out_valid  = (state == DEQ_PRESENT);
    assign rd_advance = out_valid && out_ready;

    always_comb begin
        out_word       = rd_word;
        out_word.queue = rd_queue;
    end

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            state     <= DEQ_IDLE;
            rd_queue  <= '0;
            deq_ack   <= 1'b0;
            deq_empty <= 1'b0;
        end else begin
            case (state)
                DEQ_IDLE: begin
                    if (deq_req) begin
                        rd_queue <= deq_queue;
                        if (queue_empty[deq_queue]) begin
                            deq_ack   <= 1'b1;
                            deq_empty <= 1'b1;
                            state     <= DEQ_ACK;
                        end else begin
                            state <= DEQ_READ;
                        end
                    end
                end
                // Wait here while the rest of the packet is still arriving
                DEQ_READ: begin
                    if (!queue_empty[rd_queue]) begin
                        state <= DEQ_PRESENT;
                    end
                end
                DEQ_PRESENT: begin
                    if (out_ready) begin
                        if (rd_word.last) begin
                            deq_ack   <= 1'b1;
                            deq_empty <= 1'b0;
                            state     <= DEQ_ACK;
                        end else begin
                            state <= DEQ_READ;
                        end
                    end
                end
                DEQ_ACK: begin
                    if (!deq_req) begin
                        deq_ack <= 1'b0;
                        state   <= DEQ_IDLE;
                    end
                end
                default: state <= DEQ_IDLE;
            endcase
        end
    end

    // Memory keeps returning the same word until the head advances
    a_out_stable: assert property (
        @(posedge packet_in) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_word)
    );

    // Scheduler holds the request and its queue until the ack
    a_req_held: assert property (
        @(posedge packet_in) disable iff (!arst_n)
        deq_req && !deq_ack |=> deq_ack || (deq_req && $stable(deq_queue))
    );

endmodule

// File: verilog/queue_occupancy_counter.sv
////////////////////
// Per-queue word counts and empty flags
////////////////////
`timescale 1ns/1ps
`include "queue_consts.svh"

module queue_occupancy_counter (
    input  logic                             packet_in,
    input  logic                             arst_n,
    input  logic                             wr_en,
    input  logic [`QUEUE_NUM_QUEUES_LOG-1:0] wr_queue,
    input  logic                             rd_advance,
    input  logic [`QUEUE_NUM_QUEUES_LOG-1:0] rd_queue,
    output queue_pkg::queue_occupancy_t      occupancy,
    output logic [`QUEUE_NUM_QUEUES-1:0]     queue_empty
);
    import queue_pkg::*;

    queue_occupancy_t count_next;

    // Write and read may hit the same queue in one cycle
    always_comb begin
        count_next = occupancy;
        for (int q = 0; q < `QUEUE_NUM_QUEUES; q++) begin
            if (wr_en && wr_queue == q) begin
                count_next[q] = count_next[q] + 1'b1;
            end
            if (rd_advance && rd_queue == q) begin
                count_next[q] = count_next[q] - 1'b1;
            end
            queue_empty[q] = (occupancy[q] == '0);
        end
    end

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            occupancy <= '0;
        end else begin
            occupancy <= count_next;
        end
    end

    a_no_negative: assert property (
        @(posedge packet_in) disable iff (!arst_n) rd_advance |-> !queue_empty[rd_queue]
    );

endmodule

// File: verilog/queue_pointer_table.sv
////////////////////
// Queue head and tail pointers, page links, allocation and release
////////////////////
`timescale 1ns/1ps
`include "queue_consts.svh"

module queue_pointer_table (
    input  logic                             packet_in,
    input  logic                             arst_n,
    input  queue_pkg::packet_word_t          in_word,
    input  logic                             in_valid,
    output logic                             in_ready,
    input  logic [`QUEUE_NUM_QUEUES-1:0]     queue_empty,
    input  logic [`QUEUE_NUM_PAGES_LOG-1:0]  alloc_page,
    input  logic                             alloc_avail,
    output logic                             alloc_take,
    output logic                             free_valid,
    output logic [`QUEUE_NUM_PAGES_LOG-1:0]  free_page,
    output logic                             wr_en,
    output queue_pkg::mem_addr_t             wr_addr,
    output queue_pkg::packet_word_t          wr_word,
    input  logic [`QUEUE_NUM_QUEUES_LOG-1:0] rd_queue,
    input  logic                             rd_advance,
    output queue_pkg::mem_addr_t             rd_addr
);

    logic [`QUEUE_NUM_PAGES_LOG-1:0]      head_page [`QUEUE_NUM_QUEUES];
    logic [`QUEUE_WORDS_PER_PAGE_LOG-1:0] head_off  [`QUEUE_NUM_QUEUES];
    logic [`QUEUE_NUM_PAGES_LOG-1:0]      tail_page [`QUEUE_NUM_QUEUES];
    logic [`QUEUE_WORDS_PER_PAGE_LOG-1:0] tail_off  [`QUEUE_NUM_QUEUES];
    logic [`QUEUE_NUM_PAGES_LOG-1:0]      link      [`QUEUE_NUM_PAGES];

    logic                            new_page;
    logic                            link_wr;
    logic [`QUEUE_NUM_PAGES_LOG-1:0] link_page;
    logic                            head_wrap;
    logic [`QUEUE_NUM_PAGES_LOG-1:0] next_head;

    ////////////////////
    // Enqueue side
    always_comb begin
        new_page       = (tail_off[in_word.queue] == '0);
        in_ready       = !new_page || alloc_avail;
        wr_en          = in_valid && in_ready;
        alloc_take     = wr_en && new_page;
        // Only a queue that still holds words has a tail page to chain from
        link_wr        = alloc_take && !queue_empty[in_word.queue];
        link_page      = tail_page[in_word.queue];
        wr_addr.page   = new_page ? alloc_page : tail_page[in_word.queue];
        wr_addr.offset = tail_off[in_word.queue];
        wr_word        = in_word;
    end

    ////////////////////
    // Dequeue side
    always_comb begin
        rd_addr.page   = head_page[rd_queue];
        rd_addr.offset = head_off[rd_queue];
        head_wrap      = (head_off[rd_queue] == '1);
        free_valid     = rd_advance && head_wrap;
        free_page      = head_page[rd_queue];
        // Link being written this cycle is not in the table yet
        if (link_wr && link_page == head_page[rd_queue]) begin
            next_head = alloc_page;
        end else begin
            next_head = link[head_page[rd_queue]];
        end
    end

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int q = 0; q < `QUEUE_NUM_QUEUES; q++) begin
                head_page[q] <= '0;
                head_off[q]  <= '0;
                tail_page[q] <= '0;
                tail_off[q]  <= '0;
            end
        end else begin
            if (wr_en) begin
                tail_off[in_word.queue] <= tail_off[in_word.queue] + 1'b1;
                if (new_page) begin
                    tail_page[in_word.queue] <= alloc_page;
                    if (queue_empty[in_word.queue]) begin
                        head_page[in_word.queue] <= alloc_page;
                    end
                end
            end
            if (rd_advance) begin
                head_off[rd_queue] <= head_off[rd_queue] + 1'b1;
                if (head_wrap) begin
                    head_page[rd_queue] <= next_head;
                end
            end
        end
    end

    always_ff @(posedge packet_in) begin
        if (link_wr) begin
            link[link_page] <= alloc_page;
        end
    end

endmodule

// File: queue_memory/page_free_list.sv
////////////////////
// FIFO of free page numbers
////////////////////
`timescale 1ns/1ps
`include "queue_consts.svh"

module page_free_list (
    input  logic                            packet_in,
    input  logic                            arst_n,
    input  logic                            alloc_take,
    input  logic                            free_valid,
    input  logic [`QUEUE_NUM_PAGES_LOG-1:0] free_page,
    output logic [`QUEUE_NUM_PAGES_LOG-1:0] alloc_page,
    output logic                            alloc_avail
);

    logic [`QUEUE_NUM_PAGES_LOG-1:0] fifo [`QUEUE_NUM_PAGES];
    logic [`QUEUE_NUM_PAGES_LOG-1:0] rd_ptr;
    logic [`QUEUE_NUM_PAGES_LOG-1:0] wr_ptr;
    logic [`QUEUE_NUM_PAGES_LOG:0]   fill;

    assign alloc_page  = fifo[rd_ptr];
    assign alloc_avail = (fill != '0);

    // List starts full with every page in order
    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int p = 0; p < `QUEUE_NUM_PAGES; p++) begin
                fifo[p] <= p[`QUEUE_NUM_PAGES_LOG-1:0];
            end
            rd_ptr <= '0;
            wr_ptr <= '0;
            fill   <= `QUEUE_NUM_PAGES;
        end else begin
            if (alloc_take) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (free_valid) begin
                fifo[wr_ptr] <= free_page;
                wr_ptr       <= wr_ptr + 1'b1;
            end
            if (free_valid && !alloc_take) begin
                fill <= fill + 1'b1;
            end else if (alloc_take && !free_valid) begin
                fill <= fill - 1'b1;
            end
        end
    end

    a_no_underflow: assert property (
        @(posedge packet_in) disable iff (!arst_n) alloc_take |-> alloc_avail
    );

    a_no_overflow: assert property (
        @(posedge packet_in) disable iff (!arst_n)
        free_valid && !alloc_take |-> fill < `QUEUE_NUM_PAGES
    );

endmodule

// File: queue_memory/queue_memory.sv
////////////////////
// Word memory and byte-length memory
////////////////////
`timescale 1ns/1ps
`include "queue_consts.svh"

module queue_memory (
    input  logic                    packet_in,
    input  logic                    arst_n,
    input  logic                    wr_en,
    input  queue_pkg::mem_addr_t    wr_addr,
    input  queue_pkg::packet_word_t wr_word,
    input  queue_pkg::mem_addr_t    rd_addr,
    output queue_pkg::out_word_t    rd_word
);
    import queue_pkg::*;

    localparam int MEM_WORDS = `QUEUE_NUM_PAGES * `QUEUE_WORDS_PER_PAGE;

    logic [`QUEUE_DATA_BYTES*8-1:0] word_mem [MEM_WORDS];
    blen_entry_t                    blen_mem [MEM_WORDS];

    logic                           wr_pend;
    mem_addr_t                      wr_addr_q;
    logic [`QUEUE_DATA_BYTES*8-1:0] wr_data_q;
    blen_entry_t                    wr_blen_q;
    logic [`QUEUE_DATA_BYTES*8-1:0] rd_data_q;
    blen_entry_t                    rd_blen_q;

    // Index of the lowest clear keep bit, zero when all bytes are valid
    function automatic logic [`QUEUE_DATA_BYTES_LOG-1:0] encode_keep(
        input logic [`QUEUE_DATA_BYTES-1:0] keep
    );
        logic [`QUEUE_DATA_BYTES_LOG-1:0] enc;
        enc = '0;
        for (int i = `QUEUE_DATA_BYTES - 1; i >= 1; i--) begin
            if (!keep[i]) begin
                enc = i[`QUEUE_DATA_BYTES_LOG-1:0];
            end
        end
        return enc;
    endfunction

    function automatic logic [`QUEUE_DATA_BYTES-1:0] decode_keep(
        input logic [`QUEUE_DATA_BYTES_LOG-1:0] enc
    );
        logic [`QUEUE_DATA_BYTES-1:0] keep;
        keep = '1;
        if (enc != '0) begin
            for (int i = 0; i < `QUEUE_DATA_BYTES; i++) begin
                keep[i] = (i < enc);
            end
        end
        return keep;
    endfunction

    ////////////////////
    // Write stage
    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            wr_pend <= 1'b0;
        end else begin
            wr_pend <= wr_en;
        end
    end

    always_ff @(posedge packet_in) begin
        wr_addr_q          <= wr_addr;
        wr_data_q          <= wr_word.data;
        wr_blen_q.keep_enc <= encode_keep(wr_word.keep);
        wr_blen_q.last     <= wr_word.last;
        if (wr_pend) begin
            word_mem[wr_addr_q] <= wr_data_q;
            blen_mem[wr_addr_q] <= wr_blen_q;
        end
        // A word counted one edge ago may still sit in the write stage
        if (wr_pend && wr_addr_q == rd_addr) begin
            rd_data_q <= wr_data_q;
            rd_blen_q <= wr_blen_q;
        end else begin
            rd_data_q <= word_mem[rd_addr];
            rd_blen_q <= blen_mem[rd_addr];
        end
    end

    ////////////////////
    // Read side
    always_comb begin
        rd_word.data  = rd_data_q;
        rd_word.keep  = decode_keep(rd_blen_q.keep_enc);
        rd_word.last  = rd_blen_q.last;
        // Queue tag is filled in by the dequeue side
        rd_word.queue = '0;
    end

    a_keep_nonzero: assert property (
        @(posedge packet_in) disable iff (!arst_n) wr_en |-> wr_word.keep != '0
    );

endmodule

// File: common/queue_pkg.sv
////////////////////
// Stream structs, memory entries, occupancy array and dequeue states
////////////////////
`include "queue_consts.svh"

package queue_pkg;

    // One word on the input stream
    typedef struct packed {
        logic [`QUEUE_DATA_BYTES*8-1:0]   data;
        logic [`QUEUE_DATA_BYTES-1:0]     keep;
        logic                             last;
        logic [`QUEUE_NUM_QUEUES_LOG-1:0] queue;
    } packet_word_t;

    // One word on the output stream
    typedef struct packed {
        logic [`QUEUE_DATA_BYTES*8-1:0]   data;
        logic [`QUEUE_DATA_BYTES-1:0]     keep;
        logic                             last;
        logic [`QUEUE_NUM_QUEUES_LOG-1:0] queue;
    } out_word_t;

    // Word address: page number, then offset in the page
    typedef struct packed {
        logic [`QUEUE_NUM_PAGES_LOG-1:0]      page;
        logic [`QUEUE_WORDS_PER_PAGE_LOG-1:0] offset;
    } mem_addr_t;

    // Keep as valid byte count, all ones stored as zero
    typedef struct packed {
        logic [`QUEUE_DATA_BYTES_LOG-1:0] keep_enc;
        logic                             last;
    } blen_entry_t;

    typedef logic [`QUEUE_NUM_QUEUES-1:0][`QUEUE_COUNT_WIDTH-1:0] queue_occupancy_t;

    typedef enum logic [1:0] {
        DEQ_IDLE,
        DEQ_READ,
        DEQ_PRESENT,
        DEQ_ACK
    } deq_state_t;

endpackage

// File: common/queue_consts.svh
////////////////////
// Sizes of data words, pages, queues and word counts
////////////////////
`ifndef QUEUE_CONSTS_SVH
`define QUEUE_CONSTS_SVH

// Data word
`define QUEUE_DATA_BYTES         4
`define QUEUE_DATA_BYTES_LOG     2

// Paged word memory
`define QUEUE_WORDS_PER_PAGE     4
`define QUEUE_WORDS_PER_PAGE_LOG 2
`define QUEUE_NUM_PAGES          16
`define QUEUE_NUM_PAGES_LOG      4

// Queues and their word counts
`define QUEUE_NUM_QUEUES         4
`define QUEUE_NUM_QUEUES_LOG     2
`define QUEUE_COUNT_WIDTH        7

`endif
